// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [8:0] instr_t;
    typedef logic [1:0] rd_field_t;  // Only r0 to r3 reachable
    typedef logic [2:0] rs_field_t;
    typedef logic [3:0] imm_t;

    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_ld   = 4'b0001,
        op_st   = 4'b0010,
        op_sl   = 4'b0011,
        op_sr   = 4'b0100,
        op_stt  = 4'b0101,  // Set to
        op_stf  = 4'b0110,  // Set from
        op_spec = 4'b0111,
        op_swp  = 4'b1001,
        op_stl  = 4'b1010,
        op_sth  = 4'b1011,
        op_beq  = 4'b1100,
        op_blt  = 4'b1101,
        op_jmp  = 4'b1110
    } opcode_t;

    // Sub-codes under op_spec
    typedef enum logic [2:0] {
        spec_inc = 3'b000,
        spec_aon = 3'b001,
        spec_hlt = 3'b010,
        spec_seg = 3'b011,
        spec_pkr = 3'b100
    } spec_op_t;

    function automatic opcode_t opcode_of(instr_t instr);
        return opcode_t'(instr[8:5]);
    endfunction

    function automatic spec_op_t spec_of(instr_t instr);
        return spec_op_t'(instr[2:0]);
    endfunction

    function automatic rd_field_t rd_of(instr_t instr);
        return instr[4:3];
    endfunction

    function automatic rs_field_t rs_of(instr_t instr);
        return instr[2:0];
    endfunction

    function automatic imm_t imm_of(instr_t instr);
        return instr[3:0];
    endfunction

endpackage

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [7:0] data_t;
    typedef logic [2:0] reg_addr_t;
    typedef logic [7:0] pc_t;
    typedef logic [3:0] alu_func_t;  // Same values as the opcodes

    localparam int        num_regs          = 8;
    localparam reg_addr_t branch_target_reg = 3'd7;
    localparam reg_addr_t set_low_reg       = 3'd1;

    typedef struct packed {
        logic       swap_ctrl;
        logic [1:0] set_ctrl;       // {set active, r7 select}
        alu_func_t  alu_func;
        logic [2:0] alu_spec_func;
        reg_addr_t  reg_write_val;  // Destination of write port A
        logic       alu_src;        // Immediate nibble select
        logic       mem_write;
        logic       mem_read;
        logic       branch;
        logic       reg_write;
        logic       done_ctrl;
        logic       jmp_ctrl;
    } ctrl_t;

    typedef struct packed {
        data_t addr;
        data_t wdata;
        logic  write;
        logic  read;
    } mem_req_t;

endpackage

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import isa_pkg::*, cpu_pkg::*; (
    input  instr_t instruction,
    output ctrl_t  ctrl
);

    opcode_t   op;
    spec_op_t  spec;
    reg_addr_t rd_dest;
    reg_addr_t set_dest;

    assign op       = opcode_of(instruction);
    assign spec     = spec_of(instruction);
    assign rd_dest  = {1'b0, rd_of(instruction)};
    assign set_dest = instruction[4] ? branch_target_reg : set_low_reg;

    always_comb begin
        ctrl = '0;  // Unused codes stay no-ops
        case (op)
            op_add, op_sl, op_sr, op_stt: begin
                ctrl.reg_write_val = rd_dest;
                ctrl.alu_func      = alu_func_t'(op);
                ctrl.reg_write     = 1'b1;
            end
            op_stf: begin
                // Destination is the rs field here
                ctrl.reg_write_val = reg_addr_t'(rs_of(instruction));
                ctrl.alu_func      = alu_func_t'(op);
                ctrl.reg_write     = 1'b1;
            end
            op_spec: begin
                case (spec)
                    spec_inc, spec_aon, spec_seg, spec_pkr: begin
                        ctrl.reg_write_val = rd_dest;
                        ctrl.alu_func      = alu_func_t'(op);
                        ctrl.alu_spec_func = spec;
                        ctrl.reg_write     = 1'b1;
                    end
                    spec_hlt: begin
                        ctrl.done_ctrl = 1'b1;
                    end
                    default: begin
                        ctrl.done_ctrl = 1'b0;
                    end
                endcase
            end
            op_ld: begin
                ctrl.reg_write_val = rd_dest;
                ctrl.mem_read      = 1'b1;
                ctrl.reg_write     = 1'b1;
            end
            op_st: begin
                ctrl.mem_write = 1'b1;
            end
            op_swp: begin
                ctrl.reg_write_val = rd_dest;  // Port B takes rs
                ctrl.reg_write     = 1'b1;
                ctrl.swap_ctrl     = 1'b1;
            end
            op_stl, op_sth: begin
                ctrl.reg_write_val = set_dest;
                ctrl.alu_func      = alu_func_t'(op);
                ctrl.alu_src       = 1'b1;
                ctrl.set_ctrl      = {1'b1, instruction[4]};
                ctrl.reg_write     = 1'b1;
            end
            op_beq, op_blt: begin
                ctrl.alu_func = alu_func_t'(op);
                ctrl.branch   = 1'b1;
            end
            op_jmp: begin
                ctrl.jmp_ctrl = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, cpu_pkg::*; (
    input  ctrl_t  ctrl,
    input  instr_t instruction,
    input  data_t  rd_value,
    input  data_t  rs_value,
    input  data_t  mem_rdata,
    output data_t  result,
    output data_t  swap_result,
    output logic   branch_taken
);

    data_t       alu_out;
    data_t       nibble_value;
    logic  [2:0] shamt;
    imm_t        imm;

    function automatic data_t count_ones(data_t value);
        data_t count;
        count = '0;
        for (int i = 0; i < $bits(data_t); i++) begin
            count = count + data_t'(value[i]);
        end
        return count;
    endfunction

    assign shamt = rs_value[2:0];
    assign imm   = imm_of(instruction);

    always_comb begin
        alu_out = '0;
        case (opcode_t'(ctrl.alu_func))
            op_add: alu_out = rd_value + rs_value;  // Wraps at 256
            op_sl:  alu_out = rd_value << shamt;
            op_sr:  alu_out = rd_value >> shamt;
            op_stt: alu_out = rs_value;
            op_stf: alu_out = rd_value;
            op_spec: begin
                case (spec_op_t'(ctrl.alu_spec_func))
                    spec_inc: alu_out = rd_value + 8'd1;
                    spec_aon: alu_out = rd_value & 8'd1;
                    spec_seg: alu_out = rd_value - 8'd8;
                    spec_pkr: alu_out = count_ones(rd_value);
                    default:  alu_out = '0;
                endcase
            end
            default: alu_out = '0;
        endcase
    end

    // rd_value holds r1 or r7 for stl and sth
    assign nibble_value = (ctrl.alu_func == alu_func_t'(op_sth)) ?
                          {imm, rd_value[3:0]} : {rd_value[7:4], imm};

    assign result = ctrl.mem_read  ? mem_rdata :
                    ctrl.swap_ctrl ? rs_value :
                    ctrl.alu_src   ? nibble_value : alu_out;

    assign swap_result = rd_value;  // Goes back to rs

    assign branch_taken = ctrl.branch &&
                          ((ctrl.alu_func == alu_func_t'(op_blt)) ? (rd_value < rs_value)
                                                                  : (rd_value == rs_value));

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file import isa_pkg::*, cpu_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    input  ctrl_t  ctrl,
    input  instr_t instruction,
    input  logic   halted,
    input  data_t  result,
    input  data_t  swap_result,
    output data_t  rd_value,
    output data_t  rs_value,
    output data_t  target_value
);

    data_t     regs [num_regs];
    reg_addr_t rd_addr;
    reg_addr_t rs_addr;
    reg_addr_t set_addr;

    assign rd_addr  = {1'b0, rd_of(instruction)};
    assign rs_addr  = reg_addr_t'(rs_of(instruction));
    assign set_addr = ctrl.set_ctrl[0] ? branch_target_reg : set_low_reg;

    // Nibble sets read their own target for the merge
    assign rd_value     = ctrl.set_ctrl[1] ? regs[set_addr] : regs[rd_addr];
    assign rs_value     = regs[rs_addr];
    assign target_value = regs[branch_target_reg];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (!halted) begin
            if (ctrl.reg_write) begin
                regs[ctrl.reg_write_val] <= result;  // Port A
            end
            if (ctrl.swap_ctrl) begin
                regs[rs_addr] <= swap_result;  // Port B
            end
        end
    end

endmodule

// ==== rtl/program_counter.sv ====
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  logic  branch_taken,
    input  data_t target_value,
    output pc_t   pc,
    output logic  halted
);

    typedef enum logic {
        st_run,
        st_halted
    } state_t;

    state_t state;
    pc_t    next_pc;

    // r7 holds both branch and jump targets
    assign next_pc = (ctrl.jmp_ctrl || branch_taken) ? pc_t'(target_value) : pc + 8'd1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_run;
            pc    <= '0;
        end else begin
            case (state)
                st_run: begin
                    if (ctrl.done_ctrl) begin
                        state <= st_halted;  // pc stays on the hlt
                    end else begin
                        pc <= next_pc;
                    end
                end
                st_halted: begin
                    state <= st_halted;
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    assign halted = (state == st_halted);

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import isa_pkg::*, cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    output pc_t      pc,
    input  instr_t   instruction,
    output mem_req_t mem_req,
    input  data_t    mem_rdata,
    output logic     done
);

    ctrl_t ctrl;
    data_t rd_value;
    data_t rs_value;
    data_t target_value;
    data_t result;
    data_t swap_result;
    logic  branch_taken;
    logic  halted;
    logic  mem_enable;

    control_unit u_control_unit (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    register_file u_register_file (
        .clock        (clock),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .instruction  (instruction),
        .halted       (halted),
        .result       (result),
        .swap_result  (swap_result),
        .rd_value     (rd_value),
        .rs_value     (rs_value),
        .target_value (target_value)
    );

    execute_unit u_execute_unit (
        .ctrl         (ctrl),
        .instruction  (instruction),
        .rd_value     (rd_value),
        .rs_value     (rs_value),
        .mem_rdata    (mem_rdata),
        .result       (result),
        .swap_result  (swap_result),
        .branch_taken (branch_taken)
    );

    program_counter u_program_counter (
        .clock        (clock),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .branch_taken (branch_taken),
        .target_value (target_value),
        .pc           (pc),
        .halted       (halted)
    );

    // No memory traffic in reset or after halt
    assign mem_enable = rst_n && !halted;

    assign mem_req.addr  = rs_value;
    assign mem_req.wdata = rd_value;
    assign mem_req.write = ctrl.mem_write && mem_enable;
    assign mem_req.read  = ctrl.mem_read && mem_enable;

    assign done = halted;

endmodule

// ==== verification/cpu_core_assertions.sv ====
`timescale 1ns/1ps

module cpu_core_assertions import cpu_pkg::*; (
    input logic     clock,
    input logic     rst_n,
    input pc_t      pc,
    input mem_req_t mem_req,
    input logic     done
);

    no_read_write_overlap: assert property (@(posedge clock) disable iff (!rst_n)
        !(mem_req.write && mem_req.read))
        else $error("memory write and read requested together");

    no_write_when_done: assert property (@(posedge clock) disable iff (!rst_n)
        done |-> !mem_req.write)
        else $error("memory write while halted");

    pc_holds_when_done: assert property (@(posedge clock) disable iff (!rst_n)
        done |=> $stable(pc))
        else $error("pc moved while halted");

    // First edge out of reset
    done_low_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> !done)
        else $error("done high right after reset");

endmodule

// ==== verification/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb import isa_pkg::*, cpu_pkg::*;;

    localparam int test_limit = 200;
    localparam int max_cycles = 5 * (test_limit + 20);  // Five tests plus reset slack

    logic     clock;
    logic     rst_n;
    pc_t      pc;
    instr_t   instruction;
    mem_req_t mem_req;
    data_t    mem_rdata;
    logic     done;

    instr_t rom [256];
    data_t  ram [256];
    data_t  model_ram [256];
    int     prog_len;
    int     cycles;
    int     data_errors;
    int     pc_errors;
    int     flag_errors;
    int     other_errors;

    mem_req_t store_q[$];
    mem_req_t load_q[$];
    mem_req_t exp_store_q[$];
    mem_req_t exp_load_q[$];
    pc_t      exp_pc;

    cpu_core u_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .pc          (pc),
        .instruction (instruction),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .done        (done)
    );

    bind cpu_core cpu_core_assertions u_assertions (
        .clock   (clock),
        .rst_n   (rst_n),
        .pc      (pc),
        .mem_req (mem_req),
        .done    (done)
    );

    assign instruction = rom[pc];
    assign mem_rdata   = ram[mem_req.addr];

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        if (mem_req.write) ram[mem_req.addr] <= mem_req.wdata;
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Run stopped at the cycle limit of %0d", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Middle of the cycle, requests are settled
    always @(negedge clock) begin
        if (rst_n && mem_req.write) store_q.push_back(mem_req);
        if (rst_n && mem_req.read) load_q.push_back('{mem_req.addr, mem_rdata, 1'b0, 1'b1});
    end

    function automatic instr_t enc(opcode_t op, logic [1:0] rd, logic [2:0] rs);
        return {op, rd, rs};
    endfunction

    function automatic instr_t enc_set(opcode_t op, logic sel, imm_t imm);
        return {op, sel, imm};
    endfunction

    function automatic data_t ones_in(data_t v);
        data_t cnt;
        cnt = 8'd0;
        for (int i = 0; i < 8; i++) begin
            if (v[i]) cnt = cnt + 8'd1;
        end
        return cnt;
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            pc_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic emit(instr_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) rom[i] = '0;
        prog_len = 0;
    endtask

    // Instruction-level model of the ISA
    task automatic run_model();
        data_t     r [8];
        pc_t       p;
        pc_t       p_next;
        instr_t    w;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t sel;
        data_t     a;
        data_t     b;
        exp_store_q.delete();
        exp_load_q.delete();
        model_ram = ram;
        for (int i = 0; i < 8; i++) r[i] = 8'd0;
        p = 8'd0;
        for (int step = 0; step < test_limit; step++) begin
            w = rom[p];
            rd = {1'b0, w[4:3]};
            rs = w[2:0];
            sel = w[4] ? 3'd7 : 3'd1;
            a = r[rd];
            b = r[rs];
            p_next = p + 8'd1;
            case (w[8:5])
                4'b0000: r[rd] = a + b;
                4'b0001: begin
                    r[rd] = model_ram[b];
                    exp_load_q.push_back('{b, model_ram[b], 1'b0, 1'b1});
                end
                4'b0010: begin
                    model_ram[b] = a;
                    exp_store_q.push_back('{b, a, 1'b1, 1'b0});
                end
                4'b0011: r[rd] = a << b[2:0];
                4'b0100: r[rd] = a >> b[2:0];
                4'b0101: r[rd] = b;
                4'b0110: r[rs] = a;
                4'b0111: begin
                    case (w[2:0])
                        3'd0: r[rd] = a + 8'd1;
                        3'd1: r[rd] = a & 8'd1;
                        3'd2: break;  // p stays on the hlt
                        3'd3: r[rd] = a - 8'd8;
                        3'd4: r[rd] = ones_in(a);
                        default: ;
                    endcase
                end
                4'b1001: begin
                    r[rd] = b;
                    r[rs] = a;
                end
                4'b1010: r[sel] = {r[sel][7:4], w[3:0]};
                4'b1011: r[sel] = {w[3:0], r[sel][3:0]};
                4'b1100: if (a == b) p_next = r[7];
                4'b1101: if (a < b) p_next = r[7];
                4'b1110: p_next = r[7];
                default: ;
            endcase
            p = p_next;
        end
        exp_pc = p;
    endtask

    task automatic reset_dut();
        @(posedge clock);
        #10 rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #10 rst_n = 1'b1;
        store_q.delete();
        load_q.delete();
        check_flag("done", done, 1'b0);
        check_pc("pc", pc, 8'd0);
    endtask

    task automatic compare_traffic(string test, mem_req_t got[$], mem_req_t exp[$], string kind);
        if (got.size() != exp.size()) begin
            other_errors++;
            $display("%s: saw %0d %s accesses but expected %0d",
                     test, got.size(), kind, exp.size());
        end else begin
            foreach (got[i]) begin
                check_data({test, " ", kind, " addr"}, got[i].addr, exp[i].addr);
                check_data({test, " ", kind, " data"}, got[i].wdata, exp[i].wdata);
            end
        end
    endtask

    task automatic run_test(string test);
        int n;
        run_model();
        reset_dut();
        n = 0;
        while (!done && n < test_limit) begin
            @(posedge clock);
            #10 n++;
        end
        if (!done) begin
            other_errors++;
            $display("%s: the core did not halt within %0d cycles", test, test_limit);
        end
        compare_traffic(test, store_q, exp_store_q, "store");
        compare_traffic(test, load_q, exp_load_q, "load");
        check_pc({test, " final pc"}, pc, exp_pc);
    endtask

    task automatic set_reg(logic sel, data_t value);
        emit(enc_set(op_stl, sel, value[3:0]));
        emit(enc_set(op_sth, sel, value[7:4]));
    endtask

    task automatic test_arithmetic();
        new_program();
        set_reg(1'b0, data_t'($urandom()));
        set_reg(1'b1, data_t'($urandom()));
        emit(enc(op_ld, 2'd0, 3'd1));
        emit(enc(op_ld, 2'd2, 3'd7));
        emit(enc(op_add, 2'd0, 3'd2));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_spec, 2'd0, spec_inc));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_spec, 2'd2, spec_seg));
        emit(enc(op_st, 2'd2, 3'd1));
        emit(enc(op_spec, 2'd3, spec_pkr));  // r3 is still 0
        emit(enc(op_st, 2'd3, 3'd1));
        emit(enc(op_spec, 2'd2, spec_pkr));
        emit(enc(op_st, 2'd2, 3'd1));
        emit(enc(op_spec, 2'd0, spec_aon));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_spec, 2'd0, spec_hlt));
        run_test("arithmetic");
    endtask

    task automatic test_moves();
        new_program();
        set_reg(1'b0, data_t'($urandom()));
        set_reg(1'b1, data_t'($urandom()));
        emit(enc(op_ld, 2'd0, 3'd1));
        emit(enc(op_ld, 2'd2, 3'd7));
        emit(enc(op_stf, 2'd2, 3'd4));  // Shift amount into r4
        emit(enc(op_sl, 2'd0, 3'd4));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_sr, 2'd2, 3'd4));
        emit(enc(op_st, 2'd2, 3'd1));
        emit(enc(op_stt, 2'd3, 3'd7));
        emit(enc(op_st, 2'd3, 3'd1));
        emit(enc(op_swp, 2'd0, 3'd4));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_stt, 2'd3, 3'd4));
        emit(enc(op_st, 2'd3, 3'd1));
        emit(enc(op_spec, 2'd0, spec_hlt));
        run_test("moves");
    endtask

    task automatic test_set_and_memory();
        new_program();
        set_reg(1'b0, data_t'($urandom()));
        set_reg(1'b1, data_t'($urandom()));
        emit(enc_set(op_stl, 1'b1, imm_t'($urandom())));
        emit(enc(op_ld, 2'd0, 3'd7));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_st, 2'd1, 3'd1));
        emit(enc(op_spec, 2'd0, spec_hlt));
        run_test("set_and_memory");
    endtask

    task automatic test_control_flow();
        new_program();
        emit(enc_set(op_stl, 1'b0, 4'd3));
        emit(enc(op_stt, 2'd3, 3'd1));
        emit(enc_set(op_stl, 1'b1, 4'd4));
        emit(enc(op_add, 2'd0, 3'd2));
        emit(enc(op_spec, 2'd0, spec_inc));  // Loop head at 4
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_blt, 2'd0, 3'd3));
        emit(enc_set(op_stl, 1'b1, 4'd10));
        emit(enc(op_beq, 2'd0, 3'd3));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc_set(op_stl, 1'b1, 4'd13));
        emit(enc(op_jmp, 2'd0, 3'd0));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_beq, 2'd0, 3'd2));
        emit(enc(op_st, 2'd3, 3'd1));
        emit(enc(op_spec, 2'd0, spec_hlt));
        run_test("control_flow");
    endtask

    task automatic test_halt_and_nops();
        new_program();
        set_reg(1'b0, data_t'($urandom()));
        emit(enc(op_ld, 2'd0, 3'd1));
        emit({4'b1000, 5'b01010});
        emit({4'b1111, 5'b10101});
        emit(enc(op_spec, 2'd0, 3'd5));
        emit(enc(op_spec, 2'd1, 3'd7));
        emit(enc(op_st, 2'd0, 3'd1));
        emit(enc(op_spec, 2'd0, spec_hlt));
        emit(enc(op_st, 2'd0, 3'd1));
        run_test("halt_and_nops");
        // A store under the held pc must stay blocked
        rom[exp_pc] = enc(op_st, 2'd0, 3'd1);
        repeat (5) @(posedge clock);
        #10;
        check_flag("done", done, 1'b1);
        check_pc("held pc", pc, exp_pc);
        if (store_q.size() != exp_store_q.size()) begin
            other_errors++;
            $display("halt_and_nops: a store happened after halt");
        end
        reset_dut();
        @(posedge clock);
        #10;
        check_pc("restart pc", pc, 8'd1);
    endtask

    initial begin
        rst_n = 1'b0;
        cycles = 0;
        data_errors = 0;
        pc_errors = 0;
        flag_errors = 0;
        other_errors = 0;
        void'($urandom(50));
        for (int i = 0; i < 256; i++) ram[i] = data_t'($urandom());
        new_program();
        test_arithmetic();
        test_moves();
        test_set_and_memory();
        test_control_flow();
        test_halt_and_nops();
        $display("errors: data %0d, pc %0d, flag %0d, other %0d",
                 data_errors, pc_errors, flag_errors, other_errors);
        if (data_errors + pc_errors + flag_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/isa_pkg.sv
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/execute_unit.sv
rtl/register_file.sv
rtl/program_counter.sv
rtl/cpu_core.sv
verification/cpu_core_assertions.sv
verification/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, then look for the pass line in the simulation output
verilator --binary --timing --assert -f src.f --top-module cpu_core_tb -o cpu_core_sim \
    && ./obj_dir/cpu_core_sim | grep "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
